// ==== src.f ====
logic/rv_ex_pkg.sv
logic/alu.sv
logic/branch_cmp.sv
logic/ex_forward_unit.sv
logic/instruction_execute.sv
logic/mem_access.sv
logic/ex_mem_top.sv
test/ex_mem_assert.sv
test/tb_ex_mem_top.sv

// ==== Bender.yml ====
package:
  name: ex_mem_pipeline

sources:
  - logic/rv_ex_pkg.sv
  - logic/alu.sv
  - logic/branch_cmp.sv
  - logic/ex_forward_unit.sv
  - logic/instruction_execute.sv
  - logic/mem_access.sv
  - logic/ex_mem_top.sv
  - target: test
    files:
      - test/ex_mem_assert.sv
      - test/tb_ex_mem_top.sv

// ==== test/tb_ex_mem_top.sv ====
`timescale 1ns/1ps

module tb_ex_mem_top;

  typedef struct {
    rv_ex_pkg::opcode_t op;
    logic [3:0]         fn;    // aluop or cmpop code
    logic [2:0]         f3;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [4:0]         rd;
    logic [31:0]        imm;
    int                 gap;   // bubbles ahead of the row
  } row_t;

  localparam logic [31:0] PC_BASE = 32'h0000_1000;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   in_valid_i;
  logic                   in_ready_o;
  rv_ex_pkg::rv_word_t    pc_i;
  rv_ex_pkg::opcode_t     op_i;
  rv_ex_pkg::aluop_t      aluop_i;
  rv_ex_pkg::cmpop_t      cmpop_i;
  rv_ex_pkg::mem_funct3_t funct3_i;
  rv_ex_pkg::reg_idx_t    rs1_i;
  rv_ex_pkg::reg_idx_t    rs2_i;
  rv_ex_pkg::reg_idx_t    rd_i;
  rv_ex_pkg::rv_word_t    rs1_data_i;
  rv_ex_pkg::rv_word_t    rs2_data_i;
  rv_ex_pkg::rv_word_t    imm_i;
  logic                   wb_valid_o;
  logic                   wb_ready_i;
  rv_ex_pkg::reg_idx_t    wb_rd_o;
  rv_ex_pkg::rv_word_t    wb_data_o;
  logic                   redirect_valid_o;
  rv_ex_pkg::rv_word_t    redirect_pc_o;

  row_t                tbl[$];
  rv_ex_pkg::rv_word_t arch_regs [32];     // program order
  rv_ex_pkg::rv_word_t commit_regs [32];   // retired, feeds issue operands
  logic [7:0]          mem_img [256];
  rv_ex_pkg::reg_idx_t exp_rd_q[$];
  rv_ex_pkg::rv_word_t exp_data_q[$];
  rv_ex_pkg::rv_word_t redir_q[$];
  logic [31:0]         lfsr;
  int                  cycles = 0;
  int                  cycle_limit = 1000;

  ex_mem_top #(.DMEM_WORDS(64)) DUT (.*);

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
  endfunction

  // ************************************************************
  // reference model
  // ************************************************************
  function automatic rv_ex_pkg::rv_word_t alu_model(input logic [3:0] fn,
                                                    input rv_ex_pkg::rv_word_t a,
                                                    input rv_ex_pkg::rv_word_t b);
    logic signed [31:0] sa;
    int                 sh;
    sa = a;
    sh = b[4:0];
    case (fn)
      rv_ex_pkg::alu_add:  return a + b;
      rv_ex_pkg::alu_sub:  return a - b;
      rv_ex_pkg::alu_sll:  return a << sh;
      rv_ex_pkg::alu_slt:  return (sa < $signed(b)) ? 32'd1 : 32'd0;
      rv_ex_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
      rv_ex_pkg::alu_xor:  return a ^ b;
      rv_ex_pkg::alu_srl:  return a >> sh;
      rv_ex_pkg::alu_sra:  return sa >>> sh;
      rv_ex_pkg::alu_or:   return a | b;
      default:             return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] fn, input rv_ex_pkg::rv_word_t a,
                                        input rv_ex_pkg::rv_word_t b);
    case (fn)
      rv_ex_pkg::beq:  return a == b;
      rv_ex_pkg::bne:  return a != b;
      rv_ex_pkg::blt:  return $signed(a) < $signed(b);
      rv_ex_pkg::bge:  return $signed(a) >= $signed(b);
      rv_ex_pkg::bltu: return a < b;
      rv_ex_pkg::bgeu: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic rv_ex_pkg::rv_word_t load_value(input logic [2:0] f3, input logic [7:0] a);
    logic [7:0]  b0;
    logic [7:0]  b1;
    b0 = mem_img[a];
    b1 = mem_img[a + 8'd1];
    case (f3)
      rv_ex_pkg::lb:  return {{24{b0[7]}}, b0};
      rv_ex_pkg::lbu: return {24'b0, b0};
      rv_ex_pkg::lh:  return {{16{b1[7]}}, b1, b0};
      rv_ex_pkg::lhu: return {16'b0, b1, b0};
      default:        return {mem_img[a + 8'd3], mem_img[a + 8'd2], b1, b0};
    endcase
  endfunction

  task automatic store_bytes(input logic [2:0] f3, input logic [7:0] a,
                             input rv_ex_pkg::rv_word_t d);
    int n;
    n = (f3 == rv_ex_pkg::lb) ? 1 : (f3 == rv_ex_pkg::lh) ? 2 : 4;
    for (int i = 0; i < n; i++) mem_img[a + 8'(i)] = d[8*i +: 8];
  endtask

  task automatic run_model(input row_t r, input rv_ex_pkg::rv_word_t pc);
    rv_ex_pkg::rv_word_t a;
    rv_ex_pkg::rv_word_t b;
    rv_ex_pkg::rv_word_t addr;
    rv_ex_pkg::rv_word_t res;
    logic                wr;
    a    = arch_regs[r.rs1];
    b    = arch_regs[r.rs2];
    addr = a + r.imm;
    res  = '0;
    wr   = 1'b1;
    case (r.op)
      rv_ex_pkg::op_reg:   res = alu_model(r.fn, a, b);
      rv_ex_pkg::op_imm:   res = alu_model(r.fn, a, r.imm);
      rv_ex_pkg::op_lui:   res = r.imm;
      rv_ex_pkg::op_load:  res = load_value(r.f3, addr[7:0]);
      rv_ex_pkg::op_jal: begin
        res = pc + 32'd4;
        redir_q.push_back(pc + r.imm);
      end
      rv_ex_pkg::op_jalr: begin
        res = pc + 32'd4;
        redir_q.push_back(addr & ~32'd1);
      end
      rv_ex_pkg::op_br: begin
        wr = 1'b0;
        if (branch_taken(r.fn[2:0], a, b)) redir_q.push_back(pc + r.imm);
      end
      rv_ex_pkg::op_store: begin
        wr = 1'b0;
        store_bytes(r.f3, addr[7:0], b);
      end
      default: wr = 1'b0;
    endcase
    if (wr && r.rd != 5'd0) begin
      arch_regs[r.rd] = res;
      exp_rd_q.push_back(r.rd);
      exp_data_q.push_back(res);
    end
  endtask

  // ************************************************************
  // stimulus table
  // ************************************************************
  task automatic add_row(input rv_ex_pkg::opcode_t op, input int fn, input int f3,
                         input int rs1, input int rs2, input int rd,
                         input logic [31:0] imm, input int gap);
    row_t r;
    r.op  = op;
    r.fn  = 4'(fn);
    r.f3  = 3'(f3);
    r.rs1 = 5'(rs1);
    r.rs2 = 5'(rs2);
    r.rd  = 5'(rd);
    r.imm = imm;
    r.gap = gap;
    tbl.push_back(r);
  endtask

  task automatic build_table();
    add_row(rv_ex_pkg::op_lui, 0, rv_ex_pkg::lw, 0, 0, 1, 32'h8000_0000, 0);
    add_row(rv_ex_pkg::op_imm, 0, rv_ex_pkg::lw, 0, 0, 2, 32'hFFFF_FFFB, 0);
    add_row(rv_ex_pkg::op_imm, 0, rv_ex_pkg::lw, 1, 0, 3, 32'h0000_07A3, 0);
    for (int k = 0; k < 10; k++) begin
      // reg form reads the previous reg result two slots back
      add_row(rv_ex_pkg::op_reg, k, rv_ex_pkg::lw, 1 + k % 3, (k == 0) ? 2 : 3 + k, 4 + k, 0, 0);
      add_row(rv_ex_pkg::op_imm, k, rv_ex_pkg::lw, 4 + k, 0, 14 + k,
              (k % 2) ? 32'hFFFF_FFF9 : 32'(13 + k), 0);
    end
    add_row(rv_ex_pkg::op_imm, 0, rv_ex_pkg::lw, 2, 0, 0, 32'd9, 0);   // x0 target
    add_row(rv_ex_pkg::op_reg, 0, rv_ex_pkg::lw, 0, 2, 24, 0, 0);
    for (int c = 0; c < 8; c++) begin
      if (c == 2 || c == 3) continue;
      // negative against zero, so signed and unsigned order disagree
      add_row(rv_ex_pkg::op_br, c, rv_ex_pkg::lw, 24, 0, 0, 32'(16 * (c + 1)), 0);
      add_row(rv_ex_pkg::op_br, c, rv_ex_pkg::lw, 2, 2, 0, 32'hFFFF_FFE0, 0);
      add_row(rv_ex_pkg::op_br, c, rv_ex_pkg::lw, 0, 24, 0, 32'(8 * c + 8), 0);
    end
    add_row(rv_ex_pkg::op_jal, 0, rv_ex_pkg::lw, 0, 0, 25, 32'h40, 0);
    add_row(rv_ex_pkg::op_jalr, 0, rv_ex_pkg::lw, 25, 0, 26, 32'h11, 0);
    add_row(rv_ex_pkg::op_reg, 0, rv_ex_pkg::lw, 26, 25, 27, 0, 0);
    add_row(rv_ex_pkg::op_imm, 0, rv_ex_pkg::lw, 0, 0, 28, 32'h40, 0);   // data base
    for (int o = 0; o < 4; o++)
      add_row(rv_ex_pkg::op_store, 0, rv_ex_pkg::lb, 28, 2 + o % 2, 0, 32'(o), 0);
    add_row(rv_ex_pkg::op_store, 0, rv_ex_pkg::lh, 28, 3, 0, 32'd4, 0);
    add_row(rv_ex_pkg::op_store, 0, rv_ex_pkg::lh, 28, 2, 0, 32'd6, 0);
    add_row(rv_ex_pkg::op_store, 0, rv_ex_pkg::lw, 28, 3, 0, 32'd8, 0);
    for (int o = 0; o < 4; o++) begin
      add_row(rv_ex_pkg::op_load, 0, rv_ex_pkg::lb, 28, 0, 29, 32'(o), 1);
      add_row(rv_ex_pkg::op_load, 0, rv_ex_pkg::lbu, 28, 0, 30, 32'(o), 1);
    end
    for (int o = 0; o < 4; o += 2) begin
      add_row(rv_ex_pkg::op_load, 0, rv_ex_pkg::lh, 28, 0, 29, 32'(4 + o), 1);
      add_row(rv_ex_pkg::op_load, 0, rv_ex_pkg::lhu, 28, 0, 30, 32'(4 + o), 1);
    end
    add_row(rv_ex_pkg::op_load, 0, rv_ex_pkg::lw, 28, 0, 31, 32'd8, 1);
    add_row(rv_ex_pkg::op_reg, 0, rv_ex_pkg::lw, 31, 29, 5, 0, 1);   // load use after bubble
    add_row(rv_ex_pkg::op_store, 0, rv_ex_pkg::lb, 28, 2, 0, 32'd9, 0);
    add_row(rv_ex_pkg::op_load, 0, rv_ex_pkg::lw, 28, 0, 31, 32'd8, 1);
    add_row(rv_ex_pkg::op_load, 0, rv_ex_pkg::lw, 28, 0, 30, 32'd0, 1);
  endtask

  // ************************************************************
  // issue and retire
  // ************************************************************
  task automatic wait_accept();
    logic acc;
    do begin
      rs1_data_i = commit_regs[rs1_i];   // stale while in flight
      rs2_data_i = commit_regs[rs2_i];
      @(posedge clk);
      acc = in_ready_o;
      #1;
    end while (!acc);
  endtask

  task automatic issue_row(input int i);
    row_t r;
    r = tbl[i];
    run_model(r, PC_BASE + 32'(4 * i));
    in_valid_i = 1'b0;
    repeat (r.gap) wait_accept();
    pc_i       = PC_BASE + 32'(4 * i);
    op_i       = r.op;
    aluop_i    = rv_ex_pkg::aluop_t'(r.fn);
    cmpop_i    = rv_ex_pkg::cmpop_t'(r.fn[2:0]);
    funct3_i   = rv_ex_pkg::mem_funct3_t'(r.f3);
    rs1_i      = r.rs1;
    rs2_i      = r.rs2;
    rd_i       = r.rd;
    imm_i      = r.imm;
    in_valid_i = 1'b1;
    wait_accept();
    in_valid_i = 1'b0;
  endtask

  task automatic retire_writeback();
    rv_ex_pkg::reg_idx_t e_rd;
    rv_ex_pkg::rv_word_t e_data;
    assert (exp_rd_q.size() > 0)
      else abort_run("a writeback retired when none was expected");
    e_rd   = exp_rd_q.pop_front();
    e_data = exp_data_q.pop_front();
    assert (wb_rd_o == e_rd)
      else abort_run($sformatf("FAIL %0t wb_rd_o got %0d expected %0d", $time, wb_rd_o, e_rd));
    assert (wb_data_o == e_data)
      else abort_run($sformatf("FAIL %0t wb_data_o got %h expected %h", $time, wb_data_o,
                               e_data));
    commit_regs[e_rd] = e_data;
  endtask

  task automatic match_redirect();
    rv_ex_pkg::rv_word_t e_pc;
    assert (redir_q.size() > 0)
      else abort_run("a redirect appeared with no taken branch or jump pending");
    e_pc = redir_q.pop_front();
    assert (redirect_pc_o == e_pc)
      else abort_run($sformatf("FAIL %0t redirect_pc_o got %h expected %h", $time,
                               redirect_pc_o, e_pc));
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (wb_valid_o && wb_ready_i) retire_writeback();
      if (redirect_valid_o) match_redirect();
      assert (DUT.u_assert.fail_count == 0)
        else abort_run("a bound assertion on the DUT ports failed");
    end
  end

  always @(posedge clk) begin
    #1;
    lfsr       = next_lfsr(lfsr);
    wb_ready_i = lfsr[0];   // one bit per cycle
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit)
      abort_run($sformatf("timeout after %0d cycles with results still pending", cycles));
  end

  initial begin
    rst        = 1'b1;
    lfsr       = 32'h616b;
    wb_ready_i = 1'b0;
    in_valid_i = 1'b0;
    pc_i       = '0;
    op_i       = rv_ex_pkg::op_nop;
    aluop_i    = rv_ex_pkg::alu_add;
    cmpop_i    = rv_ex_pkg::beq;
    funct3_i   = rv_ex_pkg::lw;
    rs1_i      = '0;
    rs2_i      = '0;
    rd_i       = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    imm_i      = '0;
    for (int i = 0; i < 32; i++) begin
      arch_regs[i]   = '0;
      commit_regs[i] = '0;
    end
    build_table();
    cycle_limit = 20 * tbl.size() + 100;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    for (int i = 0; i < tbl.size(); i++) issue_row(i);
    for (int n = 0; n < 50 && (exp_rd_q.size() != 0 || redir_q.size() != 0); n++)
      @(posedge clk);
    #1;
    if (exp_rd_q.size() == 0 && redir_q.size() == 0 && DUT.u_assert.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run("the run ended with expected writebacks or redirects still outstanding");
    end
  end

endmodule

// ==== test/ex_mem_assert.sv ====
`timescale 1ns/1ps

module ex_mem_assert (
  input logic                clk,
  input logic                rst,
  input logic                in_ready_i,
  input logic                wb_valid_i,
  input logic                wb_ready_i,
  input rv_ex_pkg::reg_idx_t wb_rd_i,
  input rv_ex_pkg::rv_word_t wb_data_i,
  input logic                redirect_valid_i
);

  int unsigned fail_count = 0;   // read by the testbench

  // held writeback must not move
  hold_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_valid_i && !wb_ready_i) |=> (wb_valid_i && $stable(wb_rd_i) && $stable(wb_data_i)))
    else begin
      fail_count++;
      $error("writeback changed while held by back-pressure");
    end

  ready_rule: assert property (@(posedge clk) disable iff (rst)
    in_ready_i == !(wb_valid_i && !wb_ready_i))
    else begin
      fail_count++;
      $error("in_ready_o does not follow the writeback stall");
    end

  reset_clear: assert property (@(posedge clk) rst |=> (!wb_valid_i && !redirect_valid_i))
    else begin
      fail_count++;
      $error("writeback or redirect valid after reset");
    end

endmodule

bind ex_mem_top ex_mem_assert u_assert (
  .clk              (clk),
  .rst              (rst),
  .in_ready_i       (in_ready_o),
  .wb_valid_i       (wb_valid_o),
  .wb_ready_i       (wb_ready_i),
  .wb_rd_i          (wb_rd_o),
  .wb_data_i        (wb_data_o),
  .redirect_valid_i (redirect_valid_o)
);

// ==== logic/ex_mem_top.sv ====
`timescale 1ns/1ps

module ex_mem_top #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  rv_ex_pkg::rv_word_t    pc_i,
  input  rv_ex_pkg::opcode_t     op_i,
  input  rv_ex_pkg::aluop_t      aluop_i,
  input  rv_ex_pkg::cmpop_t      cmpop_i,
  input  rv_ex_pkg::mem_funct3_t funct3_i,
  input  rv_ex_pkg::reg_idx_t    rs1_i,
  input  rv_ex_pkg::reg_idx_t    rs2_i,
  input  rv_ex_pkg::reg_idx_t    rd_i,
  input  rv_ex_pkg::rv_word_t    rs1_data_i,
  input  rv_ex_pkg::rv_word_t    rs2_data_i,
  input  rv_ex_pkg::rv_word_t    imm_i,
  output logic                   wb_valid_o,
  input  logic                   wb_ready_i,
  output rv_ex_pkg::reg_idx_t    wb_rd_o,
  output rv_ex_pkg::rv_word_t    wb_data_o,
  output logic                   redirect_valid_o,
  output rv_ex_pkg::rv_word_t    redirect_pc_o
);

  logic                   stall;
  logic                   mem_valid;
  rv_ex_pkg::opcode_t     mem_op;
  rv_ex_pkg::reg_idx_t    mem_rd;
  rv_ex_pkg::rv_word_t    mem_result;
  rv_ex_pkg::rv_word_t    mem_store_data;
  rv_ex_pkg::byte_en_t    mem_byte_en;
  rv_ex_pkg::mem_funct3_t mem_funct3;

  assign stall      = wb_valid_o && !wb_ready_i;   // held writeback freezes both stages
  assign in_ready_o = !stall;

  instruction_execute u_ex (
    .clk              (clk),
    .rst              (rst),
    .stall_i          (stall),
    .in_valid_i       (in_valid_i),
    .pc_i             (pc_i),
    .op_i             (op_i),
    .aluop_i          (aluop_i),
    .cmpop_i          (cmpop_i),
    .funct3_i         (funct3_i),
    .rs1_i            (rs1_i),
    .rs2_i            (rs2_i),
    .rd_i             (rd_i),
    .rs1_data_i       (rs1_data_i),
    .rs2_data_i       (rs2_data_i),
    .imm_i            (imm_i),
    .wb_valid_i       (wb_valid_o),
    .wb_rd_i          (wb_rd_o),
    .wb_data_i        (wb_data_o),
    .mem_valid_o      (mem_valid),
    .mem_op_o         (mem_op),
    .mem_rd_o         (mem_rd),
    .mem_result_o     (mem_result),
    .mem_store_data_o (mem_store_data),
    .mem_byte_en_o    (mem_byte_en),
    .mem_funct3_o     (mem_funct3),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  mem_access #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_ma (
    .clk              (clk),
    .rst              (rst),
    .stall_i          (stall),
    .mem_valid_i      (mem_valid),
    .mem_op_i         (mem_op),
    .mem_rd_i         (mem_rd),
    .mem_result_i     (mem_result),
    .mem_store_data_i (mem_store_data),
    .mem_byte_en_i    (mem_byte_en),
    .mem_funct3_i     (mem_funct3),
    .wb_valid_o       (wb_valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o)
  );

endmodule

// ==== logic/mem_access.sv ====
`timescale 1ns/1ps

module mem_access #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_i,
  input  logic                   mem_valid_i,
  input  rv_ex_pkg::opcode_t     mem_op_i,
  input  rv_ex_pkg::reg_idx_t    mem_rd_i,
  input  rv_ex_pkg::rv_word_t    mem_result_i,
  input  rv_ex_pkg::rv_word_t    mem_store_data_i,
  input  rv_ex_pkg::byte_en_t    mem_byte_en_i,
  input  rv_ex_pkg::mem_funct3_t mem_funct3_i,
  output logic                   wb_valid_o,
  output rv_ex_pkg::reg_idx_t    wb_rd_o,
  output rv_ex_pkg::rv_word_t    wb_data_o
);

  localparam int AW = $clog2(DMEM_WORDS);

  rv_ex_pkg::rv_word_t dmem [DMEM_WORDS];
  logic [AW-1:0]       word_idx;
  logic [1:0]          offs;
  rv_ex_pkg::rv_word_t rd_word;
  rv_ex_pkg::rv_word_t st_lanes;
  rv_ex_pkg::rv_word_t load_data;
  rv_ex_pkg::rv_word_t wb_next;
  logic [7:0]          ld_byte;
  logic [15:0]         ld_half;
  logic                do_store;

  assign word_idx = mem_result_i[AW+1:2];
  assign offs     = mem_result_i[1:0];
  assign rd_word  = dmem[word_idx];

  // ************************************************************
  // store path
  // ************************************************************
  always_comb begin
    case (mem_funct3_i)
      rv_ex_pkg::lb: st_lanes = {4{mem_store_data_i[7:0]}};
      rv_ex_pkg::lh: st_lanes = {2{mem_store_data_i[15:0]}};
      default:       st_lanes = mem_store_data_i;
    endcase
  end

  // only on the edge where the entry moves on
  assign do_store = !stall_i && mem_valid_i && (mem_op_i == rv_ex_pkg::op_store);

  always_ff @(posedge clk) begin
    if (do_store) begin
      for (int i = 0; i < 4; i++) begin
        if (mem_byte_en_i[i]) dmem[word_idx][8*i +: 8] <= st_lanes[8*i +: 8];
      end
    end
  end

  // ************************************************************
  // load extraction
  // ************************************************************
  assign ld_byte = rd_word[8*offs +: 8];
  assign ld_half = rd_word[16*offs[1] +: 16];   // aligned halves only

  always_comb begin
    case (mem_funct3_i)
      rv_ex_pkg::lb:  load_data = {{24{ld_byte[7]}}, ld_byte};
      rv_ex_pkg::lbu: load_data = {24'b0, ld_byte};
      rv_ex_pkg::lh:  load_data = {{16{ld_half[15]}}, ld_half};
      rv_ex_pkg::lhu: load_data = {16'b0, ld_half};
      default:        load_data = rd_word;
    endcase
  end

  assign wb_next = (mem_op_i == rv_ex_pkg::op_load) ? load_data : mem_result_i;

  // ************************************************************
  // MEM/WB register
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
    end else if (!stall_i) begin
      wb_valid_o <= mem_valid_i && rv_ex_pkg::writes_rd(mem_op_i) && (mem_rd_i != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      wb_rd_o   <= mem_rd_i;
      wb_data_o <= wb_next;
    end
  end

endmodule

// ==== logic/instruction_execute.sv ====
`timescale 1ns/1ps

module instruction_execute (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall_i,
  input  logic                   in_valid_i,
  input  rv_ex_pkg::rv_word_t    pc_i,
  input  rv_ex_pkg::opcode_t     op_i,
  input  rv_ex_pkg::aluop_t      aluop_i,
  input  rv_ex_pkg::cmpop_t      cmpop_i,
  input  rv_ex_pkg::mem_funct3_t funct3_i,
  input  rv_ex_pkg::reg_idx_t    rs1_i,
  input  rv_ex_pkg::reg_idx_t    rs2_i,
  input  rv_ex_pkg::reg_idx_t    rd_i,
  input  rv_ex_pkg::rv_word_t    rs1_data_i,
  input  rv_ex_pkg::rv_word_t    rs2_data_i,
  input  rv_ex_pkg::rv_word_t    imm_i,
  input  logic                   wb_valid_i,
  input  rv_ex_pkg::reg_idx_t    wb_rd_i,
  input  rv_ex_pkg::rv_word_t    wb_data_i,
  output logic                   mem_valid_o,
  output rv_ex_pkg::opcode_t     mem_op_o,
  output rv_ex_pkg::reg_idx_t    mem_rd_o,
  output rv_ex_pkg::rv_word_t    mem_result_o,
  output rv_ex_pkg::rv_word_t    mem_store_data_o,
  output rv_ex_pkg::byte_en_t    mem_byte_en_o,
  output rv_ex_pkg::mem_funct3_t mem_funct3_o,
  output logic                   redirect_valid_o,
  output rv_ex_pkg::rv_word_t    redirect_pc_o
);

  rv_ex_pkg::fwd_sel_t fwd_rs1;
  rv_ex_pkg::fwd_sel_t fwd_rs2;
  rv_ex_pkg::rv_word_t rs1_val;
  rv_ex_pkg::rv_word_t rs2_val;
  rv_ex_pkg::rv_word_t alu_b;
  rv_ex_pkg::aluop_t   alu_op;
  rv_ex_pkg::rv_word_t alu_f;
  rv_ex_pkg::rv_word_t result;
  rv_ex_pkg::rv_word_t target;
  rv_ex_pkg::byte_en_t width_mask;
  rv_ex_pkg::byte_en_t byte_en;
  logic                br_en;
  logic                taken;
  logic                mem_writes;
  logic                is_mem;

  assign mem_writes = rv_ex_pkg::writes_rd(mem_op_o);

  ex_forward_unit u_fwd (
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .mem_valid_i  (mem_valid_o),
    .mem_rd_i     (mem_rd_o),
    .mem_writes_i (mem_writes),
    .wb_valid_i   (wb_valid_i),
    .wb_rd_i      (wb_rd_i),
    .fwd_rs1_o    (fwd_rs1),
    .fwd_rs2_o    (fwd_rs2)
  );

  // ************************************************************
  // forwarding and operand select
  // ************************************************************
  always_comb begin
    case (fwd_rs1)
      rv_ex_pkg::fwd_mem: rs1_val = mem_result_o;
      rv_ex_pkg::fwd_wb:  rs1_val = wb_data_i;
      default:            rs1_val = rs1_data_i;
    endcase
    case (fwd_rs2)
      rv_ex_pkg::fwd_mem: rs2_val = mem_result_o;
      rv_ex_pkg::fwd_wb:  rs2_val = wb_data_i;
      default:            rs2_val = rs2_data_i;
    endcase
  end

  assign is_mem = (op_i == rv_ex_pkg::op_load) || (op_i == rv_ex_pkg::op_store);
  assign alu_b  = (op_i == rv_ex_pkg::op_reg) ? rs2_val : imm_i;
  // address adders share the alu
  assign alu_op = (is_mem || op_i == rv_ex_pkg::op_jalr) ? rv_ex_pkg::alu_add : aluop_i;

  alu u_alu (
    .aluop_i (alu_op),
    .a_i     (rs1_val),
    .b_i     (alu_b),
    .f_o     (alu_f)
  );

  branch_cmp u_cmp (
    .cmpop_i (cmpop_i),
    .a_i     (rs1_val),
    .b_i     (rs2_val),
    .br_en_o (br_en)
  );

  always_comb begin
    case (op_i)
      rv_ex_pkg::op_lui:  result = imm_i;
      rv_ex_pkg::op_jal,
      rv_ex_pkg::op_jalr: result = pc_i + 32'd4;   // link address
      default:            result = alu_f;
    endcase
  end

  assign target = (op_i == rv_ex_pkg::op_jalr) ? {alu_f[31:1], 1'b0} : pc_i + imm_i;
  assign taken  = (op_i == rv_ex_pkg::op_br && br_en) ||
                  (op_i == rv_ex_pkg::op_jal) || (op_i == rv_ex_pkg::op_jalr);

  // ************************************************************
  // byte enables
  // ************************************************************
  always_comb begin
    case (funct3_i)
      rv_ex_pkg::lb, rv_ex_pkg::lbu: width_mask = 4'b0001;
      rv_ex_pkg::lh, rv_ex_pkg::lhu: width_mask = 4'b0011;
      default:                       width_mask = 4'b1111;
    endcase
  end

  assign byte_en = is_mem ? rv_ex_pkg::byte_en_t'(width_mask << alu_f[1:0]) : 4'b0000;

  // ************************************************************
  // EX/MEM register
  // ************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid_o      <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      if (!stall_i) mem_valid_o <= in_valid_i;
      redirect_valid_o <= !stall_i && in_valid_i && taken;   // one-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      mem_op_o         <= op_i;
      mem_rd_o         <= rd_i;
      mem_result_o     <= result;
      mem_store_data_o <= rs2_val;
      mem_byte_en_o    <= byte_en;
      mem_funct3_o     <= funct3_i;
      redirect_pc_o    <= target;
    end
  end

endmodule

// ==== logic/ex_forward_unit.sv ====
`timescale 1ns/1ps

module ex_forward_unit (
  input  rv_ex_pkg::reg_idx_t rs1_i,
  input  rv_ex_pkg::reg_idx_t rs2_i,
  input  logic                mem_valid_i,
  input  rv_ex_pkg::reg_idx_t mem_rd_i,
  input  logic                mem_writes_i,
  input  logic                wb_valid_i,
  input  rv_ex_pkg::reg_idx_t wb_rd_i,
  output rv_ex_pkg::fwd_sel_t fwd_rs1_o,
  output rv_ex_pkg::fwd_sel_t fwd_rs2_o
);

  logic mem_src;   // EX/MEM entry can supply a value
  logic rs1_hit_mem;
  logic rs2_hit_mem;
  logic rs1_hit_wb;
  logic rs2_hit_wb;

  assign mem_src = mem_valid_i && mem_writes_i;

  // x0 reads are never forwarded
  assign rs1_hit_mem = mem_src && (rs1_i != '0) && (rs1_i == mem_rd_i);
  assign rs2_hit_mem = mem_src && (rs2_i != '0) && (rs2_i == mem_rd_i);
  assign rs1_hit_wb  = wb_valid_i && (rs1_i != '0) && (rs1_i == wb_rd_i);
  assign rs2_hit_wb  = wb_valid_i && (rs2_i != '0) && (rs2_i == wb_rd_i);

  always_comb begin
    // younger result wins
    if (rs1_hit_mem) fwd_rs1_o = rv_ex_pkg::fwd_mem;
    else if (rs1_hit_wb) fwd_rs1_o = rv_ex_pkg::fwd_wb;
    else fwd_rs1_o = rv_ex_pkg::fwd_none;

    if (rs2_hit_mem) fwd_rs2_o = rv_ex_pkg::fwd_mem;
    else if (rs2_hit_wb) fwd_rs2_o = rv_ex_pkg::fwd_wb;
    else fwd_rs2_o = rv_ex_pkg::fwd_none;
  end

endmodule

// ==== logic/branch_cmp.sv ====
`timescale 1ns/1ps

module branch_cmp (
  input  rv_ex_pkg::cmpop_t   cmpop_i,
  input  rv_ex_pkg::rv_word_t a_i,
  input  rv_ex_pkg::rv_word_t b_i,
  output logic                br_en_o
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (a_i == b_i);
  assign lt_s = $signed(a_i) < $signed(b_i);
  assign lt_u = a_i < b_i;

  always_comb begin
    case (cmpop_i)
      rv_ex_pkg::beq:  br_en_o = eq;
      rv_ex_pkg::bne:  br_en_o = !eq;
      rv_ex_pkg::blt:  br_en_o = lt_s;
      rv_ex_pkg::bge:  br_en_o = !lt_s;
      rv_ex_pkg::bltu: br_en_o = lt_u;
      rv_ex_pkg::bgeu: br_en_o = !lt_u;
      default:         br_en_o = 1'b0;
    endcase
  end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  rv_ex_pkg::aluop_t   aluop_i,
  input  rv_ex_pkg::rv_word_t a_i,
  input  rv_ex_pkg::rv_word_t b_i,
  output rv_ex_pkg::rv_word_t f_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];   // rv32 shifts use 5 bits

  always_comb begin
    case (aluop_i)
      rv_ex_pkg::alu_add:  f_o = a_i + b_i;
      rv_ex_pkg::alu_sub:  f_o = a_i - b_i;
      rv_ex_pkg::alu_sll:  f_o = a_i << shamt;
      rv_ex_pkg::alu_slt:  f_o = {31'b0, $signed(a_i) < $signed(b_i)};
      rv_ex_pkg::alu_sltu: f_o = {31'b0, a_i < b_i};
      rv_ex_pkg::alu_xor:  f_o = a_i ^ b_i;
      rv_ex_pkg::alu_srl:  f_o = a_i >> shamt;
      rv_ex_pkg::alu_sra:  f_o = rv_ex_pkg::rv_word_t'($signed(a_i) >>> shamt);
      rv_ex_pkg::alu_or:   f_o = a_i | b_i;
      rv_ex_pkg::alu_and:  f_o = a_i & b_i;
      default:             f_o = a_i + b_i;
    endcase
  end

endmodule

// ==== logic/rv_ex_pkg.sv ====
package rv_ex_pkg;

  // ************************************************************
  // word and index types
  // ************************************************************
  typedef logic [31:0] rv_word_t;   // data, address or instruction
  typedef logic [4:0]  reg_idx_t;   // x0 never written
  typedef logic [3:0]  byte_en_t;   // one bit per byte lane

  // ************************************************************
  // decoded control encodings
  // ************************************************************
  typedef enum logic [3:0] {
    op_reg   = 4'd0,
    op_imm   = 4'd1,
    op_load  = 4'd2,
    op_store = 4'd3,
    op_br    = 4'd4,
    op_jal   = 4'd5,
    op_jalr  = 4'd6,
    op_lui   = 4'd7,
    op_nop   = 4'd8
  } opcode_t;

  // and/or/xor are keywords, hence the prefix
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } aluop_t;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } cmpop_t;   // same as the branch funct3 field

  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } mem_funct3_t;   // stores reuse lb/lh/lw

  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_wb   = 2'b01,
    fwd_mem  = 2'b10
  } fwd_sel_t;

  // instruction classes that produce a register result
  function automatic logic writes_rd(opcode_t op);
    return (op == op_reg) || (op == op_imm) || (op == op_load) ||
           (op == op_jal) || (op == op_jalr) || (op == op_lui);
  endfunction

endpackage
